// File: src/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

	// pin pattern {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		ARSR = 3'b001, // auto refresh
		PRCH = 3'b010,
		ACTV = 3'b011,
		WRTE = 3'b100,
		READ = 3'b101,
		NOOP = 3'b111
	} sdram_cmd_e;

	localparam int SPACING_W = 4;

	// spacing counter load per command, indexed by the encoding.
	// a normal gap on the bus is load + 2 cycles; a repeated READ or WRTE
	// may take the fast path and go one cycle sooner
	localparam logic [7:0][SPACING_W-1:0] CMD_SPACING = {
		4'd0, // NOOP
		4'd0, // unused
		4'd2, // READ, fast gap 3
		4'd3, // WRTE, fast gap 4
		4'd0, // ACTV
		4'd1, // PRCH
		4'd9, // ARSR
		4'd0  // unused
	};

	// smallest allowed gap in cycles after each command
	localparam logic [7:0][SPACING_W-1:0] SPACING_FLOOR = {
		4'd0,  // NOOP
		4'd0,
		4'd3,  // READ
		4'd4,  // WRTE
		4'd2,  // ACTV
		4'd3,  // PRCH
		4'd11, // ARSR
		4'd0
	};

	function automatic logic is_rw(sdram_cmd_e cmd);
		return (cmd == READ) || (cmd == WRTE);
	endfunction

	function automatic logic [SPACING_W-1:0] spacing_of(sdram_cmd_e cmd);
		return CMD_SPACING[cmd];
	endfunction

	function automatic logic [SPACING_W-1:0] floor_of(sdram_cmd_e cmd);
		return SPACING_FLOOR[cmd];
	endfunction

endpackage

// File: src/sdram_addr_pkg.sv
package sdram_addr_pkg;

	typedef struct packed {
		logic [11:0] row;
		logic [1:0]  bank;
		logic [11:0] col; // 32-bit word address within the row
		logic        we;
	} client_req_t;

	typedef struct packed {
		logic [11:0] row;
		logic [1:0]  bank;
	} page_id_t;

	typedef struct packed {
		logic        a12; // no row bit above A11
		logic [11:0] row;
	} row_view_t;

	// column address skips A10, which selects auto precharge / all banks
	typedef struct packed {
		logic [1:0] high;      // A12:A11
		logic       all_banks; // A10
		logic [9:0] low;       // A9:A0
	} col_view_t;

	typedef union packed {
		row_view_t row; // ACTV
		col_view_t col; // READ, WRTE, PRCH
	} sdram_addr_u;

	typedef struct packed {
		sdram_cmd_pkg::sdram_cmd_e cmd;
		logic [1:0]                bank;
		sdram_addr_u               addr;
	} sdram_bus_t;

	function automatic sdram_addr_u row_addr(logic [11:0] row);
		sdram_addr_u a;
		a.row.a12 = 1'b0;
		a.row.row = row;
		return a;
	endfunction

	function automatic sdram_addr_u col_addr(logic [11:0] col);
		sdram_addr_u a;
		logic [11:0] half;
		half = col << 1; // two 16-bit beats per client word
		a.col.high = half[11:10];
		a.col.all_banks = 1'b0;
		a.col.low = half[9:0];
		return a;
	endfunction

	function automatic sdram_addr_u prch_addr();
		sdram_addr_u a;
		a.col.high = 2'b00;
		a.col.all_banks = 1'b1;
		a.col.low = 10'h000;
		return a;
	endfunction

endpackage

// File: src/refresh_timer.sv
`timescale 1ns/1ps

module refresh_timer #(
	parameter int REFRESH_INTERVAL = 975
) (
	input  logic CLK,
	input  logic RST,
	output logic refresh_strobe
);

	localparam int CNT_W = $clog2(REFRESH_INTERVAL);

	logic [CNT_W-1:0] count;
	logic             wrap;

	assign wrap = (count == CNT_W'(REFRESH_INTERVAL - 1));

	// strobe is a toggle, consumer keeps its own ack copy
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			count <= '0;
			refresh_strobe <= 1'b0;
		end
		else if (wrap)
		begin
			count <= '0;
			refresh_strobe <= ~refresh_strobe; // one refresh owed
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

	a_count_in_range: assert property (
		@(posedge CLK) disable iff (!RST)
		count < REFRESH_INTERVAL
	) else $error("refresh_timer: count %0d beyond interval", count);

endmodule

// File: src/cmd_timing.sv
`timescale 1ns/1ps

module cmd_timing (
	input  logic                      CLK,
	input  logic                      RST,
	input  logic                      change_req,
	input  sdram_cmd_pkg::sdram_cmd_e next_cmd,
	input  logic                      refresh_strobe,
	output logic                      change_possible,
	output logic                      page_open,
	output logic                      refresh_time
);

	logic [sdram_cmd_pkg::SPACING_W-1:0] counter;
	sdram_cmd_pkg::sdram_cmd_e           last_cmd;
	logic                                last_rw;
	logic                                count_done;
	logic                                miss_beat;
	logic                                strobe_ack;
	logic                                second_stroke;
	logic                                accept;
	logic                                fast_path;
	logic                                do_miss_beat;

	// same READ/WRTE again may go one cycle before the counter finishes
	assign fast_path = last_rw && (next_cmd == last_cmd) && (counter == '0);
	assign change_possible = (count_done || fast_path) && second_stroke;
	assign accept = change_possible && change_req;

	assign refresh_time = strobe_ack ^ refresh_strobe; // debt outstanding
	assign do_miss_beat = miss_beat && (next_cmd == sdram_cmd_pkg::PRCH);

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			counter <= '1; // let the bus settle after reset
			last_cmd <= sdram_cmd_pkg::NOOP;
			last_rw <= 1'b0;
			count_done <= 1'b0;
			miss_beat <= 1'b0;
			strobe_ack <= refresh_strobe;
			second_stroke <= 1'b0;
			page_open <= 1'b0;
		end
		else if (accept)
		begin
			second_stroke <= 1'b0; // dead cycle after every acceptance
			last_cmd <= next_cmd;
			last_rw <= sdram_cmd_pkg::is_rw(next_cmd);

			if (next_cmd != sdram_cmd_pkg::NOOP)
			begin
				counter <= sdram_cmd_pkg::spacing_of(next_cmd);
				count_done <= 1'b0;
				miss_beat <= (next_cmd == sdram_cmd_pkg::WRTE); // write recovery
			end

			if (next_cmd == sdram_cmd_pkg::ACTV)
				page_open <= 1'b1;
			if (next_cmd == sdram_cmd_pkg::PRCH)
				page_open <= 1'b0;
			if (next_cmd == sdram_cmd_pkg::ARSR)
				strobe_ack <= refresh_strobe; // debt paid
		end
		else
		begin
			if (!change_possible)
				second_stroke <= 1'b1;

			if (!count_done)
			begin
				if (counter != '0)
				begin
					counter <= counter - 1'b1;
				end
				else if (do_miss_beat)
				begin
					miss_beat <= 1'b0; // hold one extra cycle before PRCH
				end
				else
				begin
					miss_beat <= 1'b0;
					count_done <= 1'b1;
				end
			end
		end
	end

	a_arsr_page_closed: assert property (
		@(posedge CLK) disable iff (!RST)
		(accept && (next_cmd == sdram_cmd_pkg::ARSR)) |-> !page_open
	) else $error("cmd_timing: ARSR accepted with a page open");

endmodule

// File: src/page_cmd_select.sv
`timescale 1ns/1ps

module page_cmd_select #(
	parameter int ACT_HOLD = 5
) (
	input  logic                        CLK,
	input  logic                        RST,
	input  sdram_addr_pkg::client_req_t req,
	input  logic                        do_act,
	input  logic                        change_possible,
	input  logic                        page_open,
	input  logic                        refresh_time,
	output sdram_cmd_pkg::sdram_cmd_e   next_cmd,
	output logic                        change_req,
	output logic                        command_latched,
	output sdram_addr_pkg::sdram_bus_t  bus
);

	localparam int AGE_W = $clog2(ACT_HOLD + 1);

	sdram_addr_pkg::page_id_t    page_q;
	sdram_addr_pkg::page_id_t    req_page;
	sdram_addr_pkg::sdram_addr_u next_addr;
	sdram_addr_pkg::sdram_addr_u bus_addr;
	sdram_cmd_pkg::sdram_cmd_e   cmd_buf;
	sdram_cmd_pkg::sdram_cmd_e   rw_cmd;
	sdram_cmd_pkg::sdram_cmd_e   bus_cmd;
	logic [1:0]                  bus_bank;
	logic [AGE_W-1:0]            page_age;
	logic                        page_old;
	logic                        refresh_time_q;
	logic                        page_hit;
	logic                        accept;

	assign req_page = '{row: req.row, bank: req.bank};
	assign page_hit = !refresh_time && page_open && (req_page == page_q);
	assign rw_cmd = req.we ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ;

	assign next_cmd = page_hit ? rw_cmd : cmd_buf;
	assign change_req = do_act || refresh_time_q;
	assign accept = change_possible && change_req; // same rule as cmd_timing
	assign command_latched = page_hit && do_act && change_possible;

	assign page_old = (page_age == AGE_W'(ACT_HOLD));

	assign bus = '{cmd: bus_cmd, bank: bus_bank, addr: bus_addr};

	always_comb
	begin
		case (next_cmd)
			sdram_cmd_pkg::READ,
			sdram_cmd_pkg::WRTE: next_addr = sdram_addr_pkg::col_addr(req.col);
			sdram_cmd_pkg::ACTV: next_addr = sdram_addr_pkg::row_addr(req.row);
			sdram_cmd_pkg::PRCH: next_addr = sdram_addr_pkg::prch_addr();
			default:             next_addr = '0;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			refresh_time_q <= 1'b0;
			cmd_buf <= sdram_cmd_pkg::NOOP;
			page_age <= '0;
			bus_cmd <= sdram_cmd_pkg::NOOP;
		end
		else
		begin
			refresh_time_q <= refresh_time;
			bus_cmd <= accept ? next_cmd : sdram_cmd_pkg::NOOP;

			if (accept && (next_cmd == sdram_cmd_pkg::ACTV))
				page_age <= '0;
			else if (!page_old)
				page_age <= page_age + 1'b1; // saturates at ACT_HOLD

			// used next cycle when the request misses the open page
			if (page_open)
				cmd_buf <= page_old ? sdram_cmd_pkg::PRCH : sdram_cmd_pkg::NOOP;
			else if (refresh_time)
				cmd_buf <= sdram_cmd_pkg::ARSR;
			else
				cmd_buf <= sdram_cmd_pkg::ACTV;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (accept)
		begin
			bus_bank <= req.bank;
			bus_addr <= next_addr;
			if (next_cmd == sdram_cmd_pkg::ACTV)
				page_q <= req_page;
		end
	end

	// page_open comes from cmd_timing, bus from this block
	a_rw_in_open_page: assert property (
		@(posedge CLK) disable iff (!RST)
		sdram_cmd_pkg::is_rw(bus.cmd) |-> page_open
	) else $error("page_cmd_select: %s on bus with no open page", bus.cmd.name());

endmodule

// File: src/sdram_cmd_ctrl.sv
`timescale 1ns/1ps

module sdram_cmd_ctrl #(
	parameter int REFRESH_INTERVAL = 975, // 7.8 us at 125 MHz
	parameter int ACT_HOLD         = 5
) (
	input  logic                        CLK,
	input  logic                        RST,
	input  sdram_addr_pkg::client_req_t req,
	input  logic                        do_act,
	output logic                        command_latched,
	output sdram_addr_pkg::sdram_bus_t  bus
);

	logic                      refresh_strobe;
	logic                      change_possible;
	logic                      page_open;
	logic                      refresh_time;
	logic                      change_req;
	sdram_cmd_pkg::sdram_cmd_e next_cmd;

	refresh_timer #(
		.REFRESH_INTERVAL(REFRESH_INTERVAL)
	) u_refresh_timer (
		.CLK            (CLK),
		.RST            (RST),
		.refresh_strobe (refresh_strobe)
	);

	// spacing, page state and refresh debt
	cmd_timing u_cmd_timing (
		.CLK             (CLK),
		.RST             (RST),
		.change_req      (change_req),
		.next_cmd        (next_cmd),
		.refresh_strobe  (refresh_strobe),
		.change_possible (change_possible),
		.page_open       (page_open),
		.refresh_time    (refresh_time)
	);

	page_cmd_select #(
		.ACT_HOLD(ACT_HOLD)
	) u_page_cmd_select (
		.CLK             (CLK),
		.RST             (RST),
		.req             (req),
		.do_act          (do_act),
		.change_possible (change_possible),
		.page_open       (page_open),
		.refresh_time    (refresh_time),
		.next_cmd        (next_cmd),
		.change_req      (change_req),
		.command_latched (command_latched),
		.bus             (bus)
	);

endmodule

// File: tb/tb_sdram_cmd_ctrl.sv
`timescale 1ns/1ps

module tb_sdram_cmd_ctrl;

	localparam int REFRESH_INTERVAL = 120; // short, so refresh lands inside the table run
	localparam int ACT_HOLD = 5;
	localparam int N_FIXED = 6;
	localparam int N_TESTS = 10;
	localparam int LATCH_TIMEOUT = 200;

	typedef struct packed {
		logic [31:0]                at_cycle;
		sdram_addr_pkg::sdram_bus_t bus;
	} bus_event_t;

	logic                        CLK;
	logic                        RST;
	sdram_addr_pkg::client_req_t req;
	logic                        do_act;
	logic                        command_latched;
	sdram_addr_pkg::sdram_bus_t  bus;

	sdram_addr_pkg::client_req_t stim [N_TESTS]; // request table
	bus_event_t                  events [$];
	int                          cycle = 0;
	int                          errors = 0;
	int                          failed_tests = 0;
	int                          arsr_count = 0;
	int                          last_cyc = -1;
	int                          last_actv_cyc = -1;
	sdram_cmd_pkg::sdram_cmd_e   last_cmd = sdram_cmd_pkg::NOOP;
	logic                        model_open = 1'b0; // reference page model
	sdram_addr_pkg::page_id_t    model_page = '0;
	logic                        timed_out = 1'b0;

	sdram_cmd_ctrl #(
		.REFRESH_INTERVAL(REFRESH_INTERVAL),
		.ACT_HOLD(ACT_HOLD)
	) UUT (
		.CLK             (CLK),
		.RST             (RST),
		.req             (req),
		.do_act          (do_act),
		.command_latched (command_latched),
		.bus             (bus)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK)
	begin
		if (!RST)
			cycle <= 0;
		else
			cycle <= cycle + 1;
	end

	// minimum gap after each command on the bus
	function automatic int min_gap(input sdram_cmd_pkg::sdram_cmd_e c);
		case (c)
			sdram_cmd_pkg::ARSR: return 11;
			sdram_cmd_pkg::WRTE: return 4;
			sdram_cmd_pkg::READ,
			sdram_cmd_pkg::PRCH: return 3;
			sdram_cmd_pkg::ACTV: return 2;
			default: return 0;
		endcase
	endfunction

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic report_mismatch(input string name, input string want, input string got);
		errors++;
		$display("ERROR at %0t: %s expected %s, actual %s", $time, name, want, got);
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("problem at %0t: %s", $time, what);
	endtask

	task automatic log_result(input string name, input int errors_before);
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
		begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// command monitor with spacing and refresh period checks
	always @(negedge CLK)
	begin
		if (RST === 1'b1 && bus.cmd !== sdram_cmd_pkg::NOOP)
		begin
			$display("  cycle %0d: %s bank %0d addr %h", cycle, bus.cmd.name(), bus.bank, bus.addr);
			if (last_cyc >= 0)
				assert (cycle - last_cyc >= min_gap(last_cmd))
				else report_mismatch($sformatf("bus.cmd gap after %s", last_cmd.name()),
					$sformatf(">= %0d", min_gap(last_cmd)), $sformatf("%0d", cycle - last_cyc));
			if (bus.cmd == sdram_cmd_pkg::PRCH && last_actv_cyc >= 0)
				assert (cycle - last_actv_cyc >= ACT_HOLD)
				else report_mismatch("bus.cmd PRCH after ACTV", $sformatf(">= %0d", ACT_HOLD),
					$sformatf("%0d", cycle - last_actv_cyc));
			if (bus.cmd == sdram_cmd_pkg::ARSR)
			begin
				arsr_count++;
				assert (cycle / REFRESH_INTERVAL == arsr_count)
				else report_problem("refresh period without exactly one ARSR");
			end
			if (bus.cmd == sdram_cmd_pkg::ACTV)
				last_actv_cyc = cycle;
			last_cyc = cycle;
			last_cmd = bus.cmd;
			events.push_back('{at_cycle: cycle, bus: bus});
		end
	end

	// walk the logged commands through the page rule and the model
	task automatic check_window(input sdram_addr_pkg::client_req_t r, input logic has_req,
		input int latch_cyc);
		sdram_cmd_pkg::sdram_cmd_e  exp_q [$];
		sdram_cmd_pkg::sdram_cmd_e  rw;
		sdram_cmd_pkg::sdram_cmd_e  want;
		sdram_addr_pkg::sdram_bus_t b;
		logic [11:0]                half;
		logic [12:0]                col_a;
		int                         i;
		rw = r.we ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ;
		half = r.col << 1;
		col_a = {half[11:10], 1'b0, half[9:0]}; // column skips A10
		if (has_req && !(model_open && model_page.row == r.row && model_page.bank == r.bank))
		begin
			if (model_open)
				exp_q.push_back(sdram_cmd_pkg::PRCH); // miss on an open page
			exp_q.push_back(sdram_cmd_pkg::ACTV);
		end
		if (has_req)
			exp_q.push_back(rw);
		for (i = 0; i < events.size(); i++)
		begin
			b = events[i].bus;
			if (b.cmd == sdram_cmd_pkg::ARSR)
			begin
				assert (!model_open) else report_problem("ARSR issued while a page was open");
				if (has_req)
				begin
					exp_q.delete(); // page closed by refresh, rule starts over
					exp_q.push_back(sdram_cmd_pkg::ACTV);
					exp_q.push_back(rw);
				end
			end
			else if (b.cmd == sdram_cmd_pkg::PRCH && (exp_q.size() == 0 ||
				exp_q[0] != sdram_cmd_pkg::PRCH))
			begin
				assert (i + 1 < events.size() && events[i + 1].bus.cmd == sdram_cmd_pkg::ARSR)
				else report_problem("precharge outside the page rule was not followed by ARSR");
			end
			else
			begin
				want = (exp_q.size() != 0) ? exp_q[0] : sdram_cmd_pkg::NOOP;
				assert (b.cmd == want) else report_mismatch("bus.cmd", want.name(), b.cmd.name());
				if (exp_q.size() != 0)
					void'(exp_q.pop_front());
			end
			if (has_req && b.cmd == sdram_cmd_pkg::ACTV)
				assert (b.addr == {1'b0, r.row} && b.bank == r.bank)
				else report_mismatch("bus.addr/bank on ACTV", $sformatf("%h/%0d", {1'b0, r.row},
					r.bank), $sformatf("%h/%0d", b.addr, b.bank));
			if (has_req && (b.cmd == sdram_cmd_pkg::READ || b.cmd == sdram_cmd_pkg::WRTE))
				assert (b.addr == col_a && b.bank == r.bank)
				else report_mismatch("bus.addr/bank on READ/WRTE", $sformatf("%h/%0d", col_a,
					r.bank), $sformatf("%h/%0d", b.addr, b.bank));
			if (b.cmd == sdram_cmd_pkg::PRCH)
				assert (b.addr.col.all_banks === 1'b1)
				else report_mismatch("bus.addr.col.all_banks", "1", $sformatf("%b",
					b.addr.col.all_banks));
			if (b.cmd == sdram_cmd_pkg::ACTV)
			begin
				model_open = 1'b1;
				model_page = '{row: b.addr.row.row, bank: b.bank};
			end
			else if (b.cmd == sdram_cmd_pkg::PRCH)
				model_open = 1'b0;
		end
		assert (exp_q.size() == 0) else report_problem("page command sequence ended early");
		if (has_req)
			assert (events.size() > 0 && events[events.size() - 1].at_cycle == latch_cyc + 1)
			else report_problem("READ/WRTE not on the bus one cycle after command_latched");
		events.delete();
	endtask

	task automatic run_request(input int idx);
		int waited;
		int latch_cyc;
		int errors_before;
		errors_before = errors;
		@(posedge CLK);
		req <= stim[idx];
		do_act <= 1'b1;
		waited = 0;
		@(negedge CLK);
		while (command_latched !== 1'b1 && waited < LATCH_TIMEOUT)
		begin
			@(negedge CLK);
			waited++;
		end
		if (command_latched !== 1'b1)
		begin
			timed_out = 1'b1;
			report_problem($sformatf("request %0d was never latched", idx));
		end
		else
		begin
			latch_cyc = cycle;
			@(posedge CLK);
			do_act <= 1'b0; // accepted on this edge
			@(posedge CLK);
			check_window(stim[idx], 1'b1, latch_cyc);
		end
		log_result($sformatf("%0d row %h bank %0d col %h we %0b", idx, stim[idx].row,
			stim[idx].bank, stim[idx].col, stim[idx].we), errors_before);
	endtask

	initial
	begin
		int i;
		int waited;
		int errors_before;
		logic [31:0] seed;
		RST = 1'b0;
		do_act = 1'b0;
		req = '0;
		stim[0] = '{row: 12'h010, bank: 2'd0, col: 12'h004, we: 1'b0}; // closed page
		stim[1] = '{row: 12'h010, bank: 2'd0, col: 12'h005, we: 1'b1}; // hit
		stim[2] = '{row: 12'h010, bank: 2'd1, col: 12'h3ff, we: 1'b1}; // bank miss
		stim[3] = '{row: 12'h3a5, bank: 2'd1, col: 12'h400, we: 1'b0};
		stim[4] = '{row: 12'h3a5, bank: 2'd1, col: 12'h7ff, we: 1'b0};
		stim[5] = '{row: 12'hfff, bank: 2'd3, col: 12'h000, we: 1'b1};
		seed = 32'h5c4b;
		for (i = N_FIXED; i < N_TESTS; i++)
		begin
			seed = next_random(seed);
			stim[i] = '{row: seed[11:0], bank: seed[13:12], col: {1'b0, seed[26:16]},
				we: seed[31]};
		end
		repeat (4) @(posedge CLK);
		RST <= 1'b1;
		errors_before = errors;
		for (i = 0; i < 20; i++)
		begin
			@(negedge CLK);
			assert (bus.cmd === sdram_cmd_pkg::NOOP)
			else report_mismatch("bus.cmd", "NOOP", $sformatf("%b", bus.cmd));
			assert (command_latched === 1'b0)
			else report_mismatch("command_latched", "0", $sformatf("%b", command_latched));
		end
		log_result("reset idle", errors_before);
		for (i = 0; i < N_TESTS && !timed_out; i++)
			run_request(i);
		if (!timed_out)
		begin
			// idle through a full refresh period with the last page still open
			errors_before = errors;
			waited = 0;
			@(negedge CLK);
			while (!(waited >= REFRESH_INTERVAL && cycle % REFRESH_INTERVAL ==
				REFRESH_INTERVAL / 2) && waited < 3 * REFRESH_INTERVAL)
			begin
				@(negedge CLK);
				waited++;
			end
			if (waited >= 3 * REFRESH_INTERVAL)
				report_problem("idle phase never reached mid refresh period");
			@(posedge CLK);
			check_window('0, 1'b0, 0);
			assert (arsr_count == cycle / REFRESH_INTERVAL && arsr_count > 0)
			else report_mismatch("ARSR count", $sformatf("%0d", cycle / REFRESH_INTERVAL),
				$sformatf("%0d", arsr_count));
			log_result("refresh idle", errors_before);
		end
		$display("%0d tests, %0d failing, %0d errors", N_TESTS + 2, failed_tests, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sdram_cmd_ctrl.f
src/sdram_cmd_pkg.sv
src/sdram_addr_pkg.sv
src/refresh_timer.sv
src/cmd_timing.sv
src/page_cmd_select.sv
src/sdram_cmd_ctrl.sv
tb/tb_sdram_cmd_ctrl.sv

// File: Bender.yml
package:
  name: sdram_cmd_ctrl

sources:
  - src/sdram_cmd_pkg.sv
  - src/sdram_addr_pkg.sv
  - src/refresh_timer.sv
  - src/cmd_timing.sv
  - src/page_cmd_select.sv
  - src/sdram_cmd_ctrl.sv
  - target: test
    files:
      - tb/tb_sdram_cmd_ctrl.sv
